// ==== bpu_pkg.sv ====
`default_nettype none

package bpu_pkg;

    // fetch address, word granular
    localparam int ADDR_W = 30;

    // all tables share one index
    localparam int IDX_W    = 6;
    localparam int TAB_SIZE = 1 << IDX_W;

    // prediction queue
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = QPTR_W + 1;

    // return stack
    localparam int RAS_DEPTH = 8;
    localparam int RAS_PTR_W = $clog2(RAS_DEPTH);
    localparam int RAS_CNT_W = RAS_PTR_W + 1;

    typedef enum logic [2:0] {
        KIND_NONE     = 3'd0,
        KIND_DIRECT   = 3'd1,
        KIND_CALL     = 3'd2,
        KIND_RET      = 3'd3,
        KIND_INDIRECT = 3'd4
    } br_kind_t;

    // xor of the IDX_W wide slices of the address
    function automatic logic [IDX_W-1:0] pc_index(input logic [ADDR_W-1:0] addr);
        logic [IDX_W-1:0] fold;
        fold = '0;
        for (int s = 0; s < ADDR_W / IDX_W; s++) begin
            fold ^= addr[s*IDX_W +: IDX_W];
        end
        return fold;
    endfunction

endpackage

`default_nettype wire

// ==== bpu_br_if.sv ====
`default_nettype none

interface bpu_br_if;
    import bpu_pkg::*;

    // one branch record
    logic              valid;
    logic [ADDR_W-1:0] pc;
    br_kind_t          kind;
    logic              taken;
    logic [ADDR_W-1:0] npc;

    modport src (
        output valid,
        output pc,
        output kind,
        output taken,
        output npc
    );

    modport dst (
        input valid,
        input pc,
        input kind,
        input taken,
        input npc
    );

endinterface

`default_nettype wire

// ==== bpu_lookup.sv ====
`default_nettype none

module bpu_lookup (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       pc_valid,
    input  logic [bpu_pkg::ADDR_W-1:0] pc,
    bpu_br_if.src                      pred,
    bpu_br_if.dst                      upd
);
    import bpu_pkg::*;

    // prediction tables
    br_kind_t             kind_tab [TAB_SIZE];
    logic [TAB_SIZE-1:0]  kind_vld;
    logic [1:0]           ctr      [TAB_SIZE];
    logic [ADDR_W-1:0]    btb      [TAB_SIZE];

    // return stack, ras_ptr is the next free slot
    logic [ADDR_W-1:0]    ras      [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ras_ptr;
    logic [RAS_PTR_W-1:0] ras_top_ptr;
    logic [RAS_CNT_W-1:0] ras_cnt;

    logic [IDX_W-1:0]     p_idx;
    logic [ADDR_W-1:0]    p_inc;
    br_kind_t             p_kind;
    logic                 p_taken;
    logic [ADDR_W-1:0]    p_npc;
    logic [IDX_W-1:0]     u_idx;

    assign p_idx       = pc_index(pc);
    assign p_inc       = pc + 1'b1;
    assign u_idx       = pc_index(upd.pc);
    assign ras_top_ptr = ras_ptr - 1'b1;

    always_comb begin
        p_kind = kind_vld[p_idx] ? kind_tab[p_idx] : KIND_NONE;
        case (p_kind)
            KIND_NONE:   p_taken = 1'b0;
            KIND_DIRECT: p_taken = ctr[p_idx][1];
            default:     p_taken = 1'b1;
        endcase
        if (!p_taken) begin
            p_npc = p_inc;
        end else if (p_kind == KIND_RET) begin
            // empty stack falls back to the sequential address
            p_npc = (ras_cnt != '0) ? ras[ras_top_ptr] : p_inc;
        end else begin
            p_npc = btb[p_idx];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pred.valid <= 1'b0;
            kind_vld   <= '0;
            ras_ptr    <= '0;
            ras_cnt    <= '0;
            for (int i = 0; i < TAB_SIZE; i++) begin
                ctr[i] <= 2'd1;
            end
        end else begin
            pred.valid <= pc_valid;
            if (upd.valid) begin
                kind_vld[u_idx] <= 1'b1;
                // saturating 2-bit counter
                if (upd.kind == KIND_DIRECT) begin
                    if (upd.taken && ctr[u_idx] != 2'd3) begin
                        ctr[u_idx] <= ctr[u_idx] + 2'd1;
                    end else if (!upd.taken && ctr[u_idx] != 2'd0) begin
                        ctr[u_idx] <= ctr[u_idx] - 2'd1;
                    end
                end
                // a push on a full stack overwrites the oldest entry
                if (upd.kind == KIND_CALL) begin
                    ras_ptr <= ras_ptr + 1'b1;
                    if (ras_cnt != RAS_CNT_W'(RAS_DEPTH)) begin
                        ras_cnt <= ras_cnt + 1'b1;
                    end
                end else if (upd.kind == KIND_RET && ras_cnt != '0) begin
                    ras_ptr <= ras_ptr - 1'b1;
                    ras_cnt <= ras_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pc_valid) begin
            pred.pc    <= pc;
            pred.kind  <= p_kind;
            pred.taken <= p_taken;
            pred.npc   <= p_npc;
        end
        if (upd.valid) begin
            kind_tab[u_idx] <= upd.kind;
            if (upd.taken && upd.kind != KIND_RET) begin
                btb[u_idx] <= upd.npc;
            end
            if (upd.kind == KIND_CALL) begin
                ras[ras_ptr] <= upd.pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bpu_pred_queue.sv ====
`default_nettype none

module bpu_pred_queue (
    input  logic  clk,
    input  logic  rstn,
    bpu_br_if.dst enq,
    bpu_br_if.src head,
    input  logic  pop,
    output logic  err_overflow,
    output logic  err_underflow
);
    import bpu_pkg::*;

    logic [ADDR_W-1:0] q_pc    [QUEUE_DEPTH];
    br_kind_t          q_kind  [QUEUE_DEPTH];
    logic              q_taken [QUEUE_DEPTH];
    logic [ADDR_W-1:0] q_npc   [QUEUE_DEPTH];

    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] count;
    logic              full;
    logic              empty;
    logic              do_push;
    logic              do_pop;

    assign full  = (count == QCNT_W'(QUEUE_DEPTH));
    assign empty = (count == '0);
    // a push while full is dropped even if a pop happens in the same cycle
    assign do_push = enq.valid && !full;
    assign do_pop  = pop && !empty;

    // oldest record, held until popped
    assign head.valid = !empty;
    assign head.pc    = q_pc[rd_ptr];
    assign head.kind  = q_kind[rd_ptr];
    assign head.taken = q_taken[rd_ptr];
    assign head.npc   = q_npc[rd_ptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            err_overflow  <= 1'b0;
            err_underflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
            // sticky until reset
            if (enq.valid && full) begin
                err_overflow <= 1'b1;
            end
            if (pop && empty) begin
                err_underflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            q_pc[wr_ptr]    <= enq.pc;
            q_kind[wr_ptr]  <= enq.kind;
            q_taken[wr_ptr] <= enq.taken;
            q_npc[wr_ptr]   <= enq.npc;
        end
    end

endmodule

`default_nettype wire

// ==== bpu_resolve.sv ====
`default_nettype none

module bpu_resolve (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       res_valid,
    input  bpu_pkg::br_kind_t          res_kind,
    input  logic                       res_taken,
    input  logic [bpu_pkg::ADDR_W-1:0] res_npc,
    bpu_br_if.dst                      head,
    bpu_br_if.src                      upd,
    output logic                       pop,
    output logic                       mis_valid,
    output logic [2:0]                 mis_flags,
    output logic [31:0]                stat_resolved,
    output logic [31:0]                stat_mispredicts
);
    import bpu_pkg::*;

    logic       hit;
    logic [2:0] cmp;

    // the queue flags underflow itself when head is not valid
    assign pop = res_valid;
    assign hit = res_valid && head.valid;

    // bit 2 npc, bit 1 kind, bit 0 taken
    assign cmp[2] = (head.npc != res_npc);
    assign cmp[1] = (head.kind != res_kind);
    assign cmp[0] = (head.taken != res_taken);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mis_valid        <= 1'b0;
            upd.valid        <= 1'b0;
            stat_resolved    <= '0;
            stat_mispredicts <= '0;
        end else begin
            mis_valid <= hit;
            upd.valid <= hit;
            if (hit) begin
                stat_resolved <= stat_resolved + 32'd1;
            end
            if (hit && (cmp != 3'b000)) begin
                stat_mispredicts <= stat_mispredicts + 32'd1;
            end
        end
    end

    // training record carries the real outcome
    always_ff @(posedge clk) begin
        if (hit) begin
            mis_flags <= cmp;
            upd.pc    <= head.pc;
            upd.kind  <= res_kind;
            upd.taken <= res_taken;
            upd.npc   <= res_npc;
        end
    end

endmodule

`default_nettype wire

// ==== bpu_top.sv ====
`default_nettype none

module bpu_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       pc_valid,
    input  logic [bpu_pkg::ADDR_W-1:0] pc,
    input  logic                       res_valid,
    input  bpu_pkg::br_kind_t          res_kind,
    input  logic                       res_taken,
    input  logic [bpu_pkg::ADDR_W-1:0] res_npc,
    output logic                       pred_valid,
    output bpu_pkg::br_kind_t          pred_kind,
    output logic                       pred_taken,
    output logic [bpu_pkg::ADDR_W-1:0] pred_npc,
    output logic                       mis_valid,
    output logic [2:0]                 mis_flags,
    output logic [31:0]                stat_resolved,
    output logic [31:0]                stat_mispredicts,
    output logic                       err_overflow,
    output logic                       err_underflow
);

    bpu_br_if pred_bus ();
    bpu_br_if head_bus ();
    bpu_br_if upd_bus ();

    logic pop;

    bpu_lookup u_lookup (
        .clk      (clk),
        .rstn     (rstn),
        .pc_valid (pc_valid),
        .pc       (pc),
        .pred     (pred_bus.src),
        .upd      (upd_bus.dst)
    );

    bpu_pred_queue u_pred_queue (
        .clk           (clk),
        .rstn          (rstn),
        .enq           (pred_bus.dst),
        .head          (head_bus.src),
        .pop           (pop),
        .err_overflow  (err_overflow),
        .err_underflow (err_underflow)
    );

    bpu_resolve u_resolve (
        .clk              (clk),
        .rstn             (rstn),
        .res_valid        (res_valid),
        .res_kind         (res_kind),
        .res_taken        (res_taken),
        .res_npc          (res_npc),
        .head             (head_bus.dst),
        .upd              (upd_bus.src),
        .pop              (pop),
        .mis_valid        (mis_valid),
        .mis_flags        (mis_flags),
        .stat_resolved    (stat_resolved),
        .stat_mispredicts (stat_mispredicts)
    );

    // predictions leave the chip as they enter the queue
    assign pred_valid = pred_bus.valid;
    assign pred_kind  = pred_bus.kind;
    assign pred_taken = pred_bus.taken;
    assign pred_npc   = pred_bus.npc;

endmodule

`default_nettype wire

// ==== bpu_assertions.sv ====
`default_nettype none

module bpu_assertions (
    input logic                       clk,
    input logic                       rstn,
    input logic                       pc_valid,
    input logic                       pred_valid,
    input logic                       res_valid,
    input logic                       mis_valid,
    input logic [bpu_pkg::QCNT_W-1:0] q_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import bpu_pkg::*;

    // one registered prediction per fetch strobe
    a_pred_follows: assert property (
        @(posedge clk) disable iff (!rstn) pred_valid == $past(pc_valid)
    ) else $error("pred_valid does not follow pc_valid by one cycle");

    a_mis_cause: assert property (
        @(posedge clk) disable iff (!rstn) mis_valid |-> $past(res_valid)
    ) else $error("mis_valid without a resolve in the previous cycle");

    a_queue_bound: assert property (
        @(posedge clk) disable iff (!rstn) q_count <= QCNT_W'(QUEUE_DEPTH)
    ) else $error("prediction queue count above its depth");

endmodule

bind bpu_top bpu_assertions u_assertions (
    .clk        (clk),
    .rstn       (rstn),
    .pc_valid   (pc_valid),
    .pred_valid (pred_valid),
    .res_valid  (res_valid),
    .mis_valid  (mis_valid),
    .q_count    (u_pred_queue.count)
);

`default_nettype wire

// ==== tb_bpu_checker.sv ====
`default_nettype none

module tb_bpu_checker (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       pc_valid,
    input  logic [bpu_pkg::ADDR_W-1:0] pc,
    input  logic                       res_valid,
    input  bpu_pkg::br_kind_t          res_kind,
    input  logic                       res_taken,
    input  logic [bpu_pkg::ADDR_W-1:0] res_npc,
    input  logic                       pred_valid,
    input  bpu_pkg::br_kind_t          pred_kind,
    input  logic                       pred_taken,
    input  logic [bpu_pkg::ADDR_W-1:0] pred_npc,
    input  logic                       mis_valid,
    input  logic [2:0]                 mis_flags,
    input  logic [31:0]                stat_resolved,
    input  logic [31:0]                stat_mispredicts,
    input  logic                       err_overflow,
    input  logic                       err_underflow,
    output int                         error_count,
    output int                         check_count
);
    timeunit 1ns;
    timeprecision 1ps;
    import bpu_pkg::*;

    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        br_kind_t          kind;
        logic              taken;
        logic [ADDR_W-1:0] npc;
    } rec_t;

    // model tables, stack and queue
    br_kind_t          m_kind [TAB_SIZE];
    logic              m_kvld [TAB_SIZE];
    logic [1:0]        m_ctr  [TAB_SIZE];
    logic [ADDR_W-1:0] m_btb  [TAB_SIZE];
    logic [ADDR_W-1:0] m_ras  [$];
    rec_t              m_queue [$];

    logic        upd_pending;
    rec_t        upd_rec;
    logic        exp_pred_valid;
    rec_t        exp_pred;
    logic        exp_mis_valid;
    logic [2:0]  exp_flags;
    logic [31:0] exp_resolved;
    logic [31:0] exp_mispredicts;
    logic        exp_ovf;
    logic        exp_unf;
    int          errors = 0;
    int          checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    function automatic rec_t predict(input logic [ADDR_W-1:0] addr);
        rec_t             r;
        logic [IDX_W-1:0] idx;
        idx     = pc_index(addr);
        r.pc    = addr;
        r.kind  = m_kvld[idx] ? m_kind[idx] : KIND_NONE;
        r.taken = (r.kind == KIND_NONE) ? 1'b0 :
                  (r.kind == KIND_DIRECT) ? m_ctr[idx][1] : 1'b1;
        if (!r.taken) begin
            r.npc = addr + ADDR_W'(1);
        end else if (r.kind == KIND_RET) begin
            r.npc = (m_ras.size() > 0) ? m_ras[$] : addr + ADDR_W'(1);
        end else begin
            r.npc = m_btb[idx];
        end
        return r;
    endfunction

    task automatic train(input rec_t u);
        logic [IDX_W-1:0] idx;
        idx         = pc_index(u.pc);
        m_kind[idx] = u.kind;
        m_kvld[idx] = 1'b1;
        if (u.kind == KIND_DIRECT) begin
            if (u.taken && m_ctr[idx] != 2'd3) begin
                m_ctr[idx] = m_ctr[idx] + 2'd1;
            end else if (!u.taken && m_ctr[idx] != 2'd0) begin
                m_ctr[idx] = m_ctr[idx] - 2'd1;
            end
        end
        if (u.taken && u.kind != KIND_RET) begin
            m_btb[idx] = u.npc;
        end
        if (u.kind == KIND_CALL) begin
            m_ras.push_back(u.pc + ADDR_W'(1));
            // oldest return address falls off
            if (m_ras.size() > RAS_DEPTH) begin
                m_ras.delete(0);
            end
        end else if (u.kind == KIND_RET && m_ras.size() > 0) begin
            m_ras.delete(m_ras.size() - 1);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < TAB_SIZE; i++) begin
            m_kvld[i] = 1'b0;
            m_ctr[i]  = 2'd1;
            m_btb[i]  = '0;
        end
        m_ras.delete();
        m_queue.delete();
        upd_pending     = 1'b0;
        exp_pred_valid  = 1'b0;
        exp_mis_valid   = 1'b0;
        exp_resolved    = '0;
        exp_mispredicts = '0;
        exp_ovf         = 1'b0;
        exp_unf         = 1'b0;
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Error: %s got %h expected %h at %0t", name, got, want, $time);
        end
    endtask

    always @(posedge clk) begin
        rec_t now_pred;
        rec_t head;
        rec_t new_rec;
        logic new_upd;
        logic was_full;
        if (!rstn) begin
            reset_model();
        end else begin
            was_full      = (m_queue.size() == QUEUE_DEPTH);
            now_pred      = predict(pc);
            new_upd       = 1'b0;
            new_rec       = '0;
            exp_mis_valid = 1'b0;
            if (res_valid && m_queue.size() == 0) begin
                exp_unf = 1'b1;
            end else if (res_valid) begin
                head          = m_queue.pop_front();
                exp_flags     = {head.npc != res_npc, head.kind != res_kind,
                                 head.taken != res_taken};
                exp_mis_valid = 1'b1;
                exp_resolved  = exp_resolved + 32'd1;
                if (exp_flags != 3'b000) begin
                    exp_mispredicts = exp_mispredicts + 32'd1;
                end
                new_upd = 1'b1;
                new_rec = '{pc: head.pc, kind: res_kind, taken: res_taken, npc: res_npc};
            end
            // last cycle's prediction reaches the queue now
            if (exp_pred_valid && was_full) begin
                exp_ovf = 1'b1;
            end else if (exp_pred_valid) begin
                m_queue.push_back(exp_pred);
            end
            // this edge's prediction still saw the old tables
            if (upd_pending) begin
                train(upd_rec);
            end
            upd_pending    = new_upd;
            upd_rec        = new_rec;
            exp_pred_valid = pc_valid;
            exp_pred       = now_pred;
        end
    end

    always @(negedge clk) begin
        if (rstn) begin
            compare("pred_valid", 32'(pred_valid), 32'(exp_pred_valid));
            if (exp_pred_valid) begin
                compare("pred_kind", 32'(pred_kind), 32'(exp_pred.kind));
                compare("pred_taken", 32'(pred_taken), 32'(exp_pred.taken));
                compare("pred_npc", 32'(pred_npc), 32'(exp_pred.npc));
            end
            compare("mis_valid", 32'(mis_valid), 32'(exp_mis_valid));
            if (exp_mis_valid) begin
                compare("mis_flags", 32'(mis_flags), 32'(exp_flags));
            end
            compare("stat_resolved", stat_resolved, exp_resolved);
            compare("stat_mispredicts", stat_mispredicts, exp_mispredicts);
            compare("err_overflow", 32'(err_overflow), 32'(exp_ovf));
            compare("err_underflow", 32'(err_underflow), 32'(exp_unf));
        end
    end

endmodule

`default_nettype wire

// ==== tb_bpu.sv ====
`default_nettype none

module tb_bpu;
    timeunit 1ns;
    timeprecision 1ps;
    import bpu_pkg::*;

    localparam int NUM_SITES  = 12;
    localparam int WAIT_LIMIT = 20;

    logic              clk;
    logic              rstn;
    logic              pc_valid;
    logic [ADDR_W-1:0] pc;
    logic              res_valid;
    br_kind_t          res_kind;
    logic              res_taken;
    logic [ADDR_W-1:0] res_npc;
    logic              pred_valid;
    br_kind_t          pred_kind;
    logic              pred_taken;
    logic [ADDR_W-1:0] pred_npc;
    logic              mis_valid;
    logic [2:0]        mis_flags;
    logic [31:0]       stat_resolved;
    logic [31:0]       stat_mispredicts;
    logic              err_overflow;
    logic              err_underflow;
    int                error_count;
    int                check_count;

    logic [31:0]       seed;
    logic [ADDR_W-1:0] site_pc   [NUM_SITES];
    br_kind_t          site_kind [NUM_SITES];
    logic [ADDR_W-1:0] site_tgt  [NUM_SITES];
    // return addresses of calls that really happened
    logic [ADDR_W-1:0] call_stack [$];

    bpu_top u_bpu_top (.*);

    tb_bpu_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic flag(input int sel);
        case (sel)
            0:       return pred_valid;
            1:       return mis_valid;
            2:       return err_overflow;
            default: return err_underflow;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_for(input int sel, input string what);
        int n;
        n = 0;
        while (!flag(sel) && n < WAIT_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!flag(sel)) begin
            $display("timeout while waiting for %s", what);
            $display("checks %0d, errors %0d", check_count, error_count);
            $display("Simulation FAILED");
            $finish;
        end
    endtask

    // back to back fetches of consecutive sites
    task automatic issue_burst(input int first, input int n);
        for (int k = 0; k < n; k++) begin
            pc_valid = 1'b1;
            pc       = site_pc[first + k];
            next_cycle();
        end
        pc_valid = 1'b0;
        wait_for(0, "pred_valid");
        next_cycle();
    endtask

    task automatic resolve_site(input int i, input logic dir, input int wait_sel);
        res_valid = 1'b1;
        res_kind  = site_kind[i];
        res_taken = (site_kind[i] == KIND_DIRECT) ? dir : (site_kind[i] != KIND_NONE);
        res_npc   = res_taken ? site_tgt[i] : site_pc[i] + ADDR_W'(1);
        if (site_kind[i] == KIND_CALL) begin
            call_stack.push_back(site_pc[i] + ADDR_W'(1));
        end
        if (site_kind[i] == KIND_RET && call_stack.size() > 0) begin
            res_npc = call_stack.pop_back();
        end
        next_cycle();
        res_valid = 1'b0;
        wait_for(wait_sel, (wait_sel == 1) ? "mis_valid" : "err_underflow");
        next_cycle();
    endtask

    task automatic predict_and_resolve(input int i, input logic dir);
        issue_burst(i, 1);
        resolve_site(i, dir, 1);
    endtask

    initial begin
        rstn      = 1'b0;
        pc_valid  = 1'b0;
        pc        = '0;
        res_valid = 1'b0;
        res_kind  = KIND_NONE;
        res_taken = 1'b0;
        res_npc   = '0;
        seed      = 32'he8e0;
        site_kind = '{KIND_DIRECT, KIND_DIRECT, KIND_DIRECT, KIND_DIRECT,
                      KIND_CALL, KIND_CALL, KIND_CALL, KIND_RET, KIND_RET, KIND_RET,
                      KIND_INDIRECT, KIND_NONE};
        // distinct table index per site
        for (int i = 0; i < NUM_SITES; i++) begin
            seed        = lcg(seed);
            site_pc[i]  = 30'h0010_0000 + ADDR_W'(i * 4);
            site_tgt[i] = seed[31:2];
        end
        repeat (10) next_cycle();
        rstn = 1'b1;
        next_cycle();

        // cold tables
        for (int i = 0; i < NUM_SITES; i++) begin
            predict_and_resolve(i, 1'b1);
        end
        // counter up to saturation, then down to zero
        repeat (4) predict_and_resolve(0, 1'b1);
        repeat (5) predict_and_resolve(0, 1'b0);
        predict_and_resolve(0, 1'b1);
        // stack overflow and a return past the bottom
        for (int k = 0; k < 10; k++) begin
            predict_and_resolve(4 + k % 3, 1'b1);
        end
        for (int k = 0; k < 11; k++) begin
            predict_and_resolve(7 + k % 3, 1'b1);
        end
        repeat (300) begin
            seed = lcg(seed);
            predict_and_resolve(int'(seed[23:16]) % NUM_SITES, seed[27]);
        end
        // queue order, overflow, underflow
        issue_burst(0, 4);
        for (int k = 0; k < 4; k++) begin
            resolve_site(k, 1'b1, 1);
        end
        issue_burst(0, 5);
        wait_for(2, "err_overflow");
        for (int k = 0; k < 4; k++) begin
            resolve_site(k, 1'b0, 1);
        end
        resolve_site(0, 1'b1, 3);
        repeat (3) next_cycle();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
bpu_pkg.sv
bpu_br_if.sv
bpu_lookup.sv
bpu_pred_queue.sv
bpu_resolve.sv
bpu_top.sv
bpu_assertions.sv
tb_bpu_checker.sv
tb_bpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the exit status of the binary
run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then echo "run failed, see $(LOG)"; exit 1; fi
	@grep -q "Simulation PASSED" $(LOG) || (echo "no result line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
